/* Bender.yml */
package:
  name: fsync_coproc

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fsync_pkg.sv
      - hdl/fsync_issue_decoder.sv
      - hdl/fsync_sync_fsm.sv
      - hdl/fsync_result_unit.sv
      - hdl/fsync_coproc.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - test/fsync_coproc_sva.sv
      - test/fsync_coproc_tb.sv

/* filelist.f */
+incdir+hdl
hdl/fsync_pkg.sv
hdl/fsync_issue_decoder.sv
hdl/fsync_sync_fsm.sv
hdl/fsync_result_unit.sv
hdl/fsync_coproc.sv
test/fsync_coproc_sva.sv
test/fsync_coproc_tb.sv

/* hdl/fsync_cfg.svh */
`ifndef FSYNC_CFG_SVH
`define FSYNC_CFG_SVH

// Word widths on the issue side
`define FSYNC_INSTR_W 32
`define FSYNC_DATA_W 32

// Barrier level sent to the network
`define FSYNC_LVL_W 4

// Completed barrier counter, wraps on overflow
`define FSYNC_CNT_W 16

// Opcode field position
`define FSYNC_OPCODE_W 7
`define FSYNC_OPCODE_OFF 0

// Function code field position
`define FSYNC_FUNC3_W 3
`define FSYNC_FUNC3_OFF 12

// Custom-2 opcode claimed by this coprocessor
`define FSYNC_OPCODE 7'h5B

// Barrier function code within custom-2
`define FSYNC_FUNC3 3'b010

`endif

/* hdl/fsync_coproc.sv */
`timescale 1ns/1ps

module fsync_coproc (
  input  logic              clk_dec_g,
  input  logic              rst_ni,
  input  logic              clear_i,

  // Issue handshake with the core
  input  logic              issue_valid_i,
  input  fsync_pkg::instr_t issue_instr_i,
  input  fsync_pkg::data_t  issue_rs0_i,
  input  logic              issue_rs_valid_i,
  output logic              issue_ready_o,
  output logic              issue_accept_o,

  // Synchronization network
  output logic              sync_o,
  output fsync_pkg::level_t level_o,
  input  logic              wake_i,
  input  logic              error_i,
  output logic              ack_o,

  // Barrier results
  output logic              result_valid_o,
  output fsync_pkg::level_t result_level_o,
  output logic              result_error_o,
  output fsync_pkg::count_t done_count_o,
  output logic              error_status_o
);

  import fsync_pkg::*;

  // Decoder and execute block
  logic   busy;
  logic   sync_start;
  level_t dec_level;

  // Execute and result block
  logic   done;
  logic   done_error;
  level_t done_level;

  // Opcode check and level capture
  fsync_issue_decoder fsync_issue_decoder_inst (
    .clk_dec_g        (clk_dec_g),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .issue_valid_i    (issue_valid_i),
    .issue_rs_valid_i (issue_rs_valid_i),
    .issue_instr_i    (issue_instr_i),
    .issue_rs0_i      (issue_rs0_i),
    .busy_i           (busy),
    .issue_ready_o    (issue_ready_o),
    .issue_accept_o   (issue_accept_o),
    .sync_start_o     (sync_start),
    .level_o          (dec_level)
  );

  // Barrier FSM toward the network
  fsync_sync_fsm fsync_sync_fsm_inst (
    .clk_dec_g    (clk_dec_g),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .sync_start_i (sync_start),
    .level_i      (dec_level),
    .wake_i       (wake_i),
    .error_i      (error_i),
    .busy_o       (busy),
    .sync_o       (sync_o),
    .level_o      (level_o),
    .ack_o        (ack_o),
    .done_o       (done),
    .done_error_o (done_error),
    .done_level_o (done_level)
  );

  // Registered reports and status
  fsync_result_unit fsync_result_unit_inst (
    .clk_dec_g      (clk_dec_g),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .done_i         (done),
    .done_error_i   (done_error),
    .done_level_i   (done_level),
    .result_valid_o (result_valid_o),
    .result_error_o (result_error_o),
    .result_level_o (result_level_o),
    .error_status_o (error_status_o),
    .done_count_o   (done_count_o)
  );

endmodule

/* hdl/fsync_issue_decoder.sv */
`timescale 1ns/1ps

`include "fsync_cfg.svh"

module fsync_issue_decoder (
  input  logic              clk_dec_g,
  input  logic              rst_ni,
  input  logic              clear_i,

  // Issue request from the core
  input  logic              issue_valid_i,
  input  logic              issue_rs_valid_i,
  input  fsync_pkg::instr_t issue_instr_i,
  input  fsync_pkg::data_t  issue_rs0_i,

  // Execute block still has a barrier in flight
  input  logic              busy_i,

  // Issue response, combinational
  output logic              issue_ready_o,
  output logic              issue_accept_o,

  // Barrier start toward the execute block
  output logic              sync_start_o,
  output fsync_pkg::level_t level_o
);

  import fsync_pkg::*;

  // Fields sliced from the offered instruction
  opcode_t opcode;
  func3_t  func3;

  logic opcode_match;
  logic func3_match;

  // Handshake completes this cycle
  logic issue_take;
  // Take of a well formed barrier instruction
  logic barrier_take;

  // Level register
  level_t level_d;
  level_t level_q;

  assign opcode = issue_instr_i[`FSYNC_OPCODE_OFF +: `FSYNC_OPCODE_W];
  assign func3  = issue_instr_i[`FSYNC_FUNC3_OFF +: `FSYNC_FUNC3_W];

  assign opcode_match = (opcode == `FSYNC_OPCODE);
  assign func3_match  = (func3 == `FSYNC_FUNC3);

  // Only our opcode gets ready
  // Held low while a barrier is pending, this is the back-pressure
  // Also low during a clear so nothing is taken and then dropped
  assign issue_ready_o = issue_valid_i & opcode_match & ~busy_i & ~clear_i;

  // Any taken instruction is accepted, malformed ones included
  assign issue_accept_o = issue_ready_o;

  assign issue_take = issue_valid_i & issue_ready_o;

  // Wrong func3 or missing operand is swallowed without a barrier
  assign barrier_take = issue_take & func3_match & issue_rs_valid_i;

  // One cycle pulse, FSM leaves IDLE on the next edge
  assign sync_start_o = barrier_take;

  // Capture the level from the low bits of rs0 at the take
  always_comb begin
    level_d = level_q;
    if (barrier_take) begin
      level_d = issue_rs0_i[`FSYNC_LVL_W-1:0];
    end
  end

  always_ff @(posedge clk_dec_g or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= '0;
    end else if (clear_i) begin
      level_q <= '0;
    end else begin
      level_q <= level_d;
    end
  end

  // Stable for the whole barrier since no new take while busy
  assign level_o = level_q;

endmodule

/* hdl/fsync_pkg.sv */
`include "fsync_cfg.svh"

package fsync_pkg;

  // Instruction word offered by the core
  typedef logic [`FSYNC_INSTR_W-1:0] instr_t;

  // Source operand from the register file
  typedef logic [`FSYNC_DATA_W-1:0] data_t;

  // Decoded instruction fields
  typedef logic [`FSYNC_OPCODE_W-1:0] opcode_t;
  typedef logic [`FSYNC_FUNC3_W-1:0] func3_t;

  // Hierarchy level of one barrier
  typedef logic [`FSYNC_LVL_W-1:0] level_t;

  // Number of finished barriers
  typedef logic [`FSYNC_CNT_W-1:0] count_t;

  // Barrier FSM toward the network
  // IDLE waits for a take
  // SYNC raises the request for one cycle
  // WAIT holds until the wake
  // ACK acknowledges and reports completion
  typedef enum logic [1:0] {
    IDLE,
    SYNC,
    WAIT,
    ACK
  } sync_state_e;

endpackage

/* hdl/fsync_result_unit.sv */
`timescale 1ns/1ps

module fsync_result_unit (
  input  logic              clk_dec_g,
  input  logic              rst_ni,
  input  logic              clear_i,

  // Completion from the execute block
  input  logic              done_i,
  input  logic              done_error_i,
  input  fsync_pkg::level_t done_level_i,

  // Per barrier report, one cycle after ACK
  output logic              result_valid_o,
  output logic              result_error_o,
  output fsync_pkg::level_t result_level_o,

  // Running status
  output logic              error_status_o,
  output fsync_pkg::count_t done_count_o
);

  import fsync_pkg::*;

  logic   valid_q;
  logic   error_q;
  logic   status_q;
  level_t level_q;
  count_t count_q;

  // Control and status registers
  always_ff @(posedge clk_dec_g or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      error_q  <= 1'b0;
      status_q <= 1'b0;
      level_q  <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      valid_q  <= 1'b0;
      error_q  <= 1'b0;
      status_q <= 1'b0;
      level_q  <= '0;
      count_q  <= '0;
    end else begin
      valid_q <= done_i;
      // Error only shown alongside a valid report
      error_q <= done_i & done_error_i;
      // Level of the last finished barrier
      if (done_i) begin
        level_q <= done_level_i;
      end
      // Counter wraps on overflow
      if (done_i) begin
        count_q <= count_q + 1'b1;
      end
      // Sticky until the next clear
      if (done_i && done_error_i) begin
        status_q <= 1'b1;
      end
    end
  end

  assign result_valid_o = valid_q;
  assign result_error_o = error_q;
  assign result_level_o = level_q;
  assign error_status_o = status_q;
  assign done_count_o   = count_q;

endmodule

/* hdl/fsync_sync_fsm.sv */
`timescale 1ns/1ps

module fsync_sync_fsm (
  input  logic              clk_dec_g,
  input  logic              rst_ni,
  input  logic              clear_i,

  // Start from the decoder
  input  logic              sync_start_i,
  input  fsync_pkg::level_t level_i,

  // Network wake with its error flag
  input  logic              wake_i,
  input  logic              error_i,

  // Back-pressure toward the decoder
  output logic              busy_o,

  // Network request and acknowledge
  output logic              sync_o,
  output fsync_pkg::level_t level_o,
  output logic              ack_o,

  // Completion toward the result block
  output logic              done_o,
  output logic              done_error_o,
  output fsync_pkg::level_t done_level_o
);

  import fsync_pkg::*;

  sync_state_e state_d;
  sync_state_e state_q;

  // Error flag sampled with the wake
  logic error_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (sync_start_i) begin
          state_d = SYNC;
        end
      end
      // Request lasts exactly one cycle
      SYNC: state_d = WAIT;
      // Wait latency is set by the network
      WAIT: begin
        if (wake_i) begin
          state_d = ACK;
        end
      end
      ACK: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_dec_g or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured at the wake edge and shown in ACK
  always_ff @(posedge clk_dec_g or negedge rst_ni) begin
    if (!rst_ni) begin
      error_q <= 1'b0;
    end else if (clear_i) begin
      error_q <= 1'b0;
    end else if ((state_q == WAIT) && wake_i) begin
      error_q <= error_i;
    end
  end

  // Outputs decoded from the state
  always_comb begin
    busy_o       = (state_q != IDLE);
    sync_o       = 1'b0;
    level_o      = '0;
    ack_o        = 1'b0;
    done_o       = 1'b0;
    done_error_o = 1'b0;
    done_level_o = '0;
    case (state_q)
      SYNC: begin
        sync_o  = 1'b1;
        level_o = level_i;
      end
      ACK: begin
        ack_o        = 1'b1;
        done_o       = 1'b1;
        done_error_o = error_q;
        done_level_o = level_i;
      end
      default: ;
    endcase
  end

endmodule

/* test/fsync_coproc_sva.sv */
`timescale 1ns/1ps

module fsync_coproc_sva (
  input logic clk_dec_g,
  input logic rst_ni,
  input logic clear_i,
  input logic issue_ready_o,
  input logic sync_o,
  input logic wake_i,
  input logic ack_o
);

  // Failed assertions seen so far
  int unsigned fail_count = 0;

  // Single cycle network request and no second one before the acknowledge
  sync_one_cycle: assert property (
    @(posedge clk_dec_g) disable iff (!rst_ni || clear_i)
    sync_o |=> (!sync_o throughout ack_o[->1])
  ) else begin
    fail_count++;
    $error("sync_o held for more than one cycle");
  end

  // Acknowledge comes one cycle after the wake
  ack_after_wake: assert property (
    @(posedge clk_dec_g) disable iff (!rst_ni || clear_i)
    wake_i |=> ack_o
  ) else begin
    fail_count++;
    $error("ack_o missing one cycle after wake_i");
  end

  // No acknowledge without a preceding wake
  ack_needs_wake: assert property (
    @(posedge clk_dec_g) disable iff (!rst_ni || clear_i)
    ack_o |-> $past(wake_i)
  ) else begin
    fail_count++;
    $error("ack_o without wake_i in the previous cycle");
  end

  // Back-pressure from the request up to the acknowledge
  no_ready_when_busy: assert property (
    @(posedge clk_dec_g) disable iff (!rst_ni || clear_i)
    sync_o |-> (!issue_ready_o throughout ack_o[->1])
  ) else begin
    fail_count++;
    $error("issue_ready_o high while a barrier is pending");
  end

endmodule

bind fsync_coproc fsync_coproc_sva fsync_coproc_sva_inst (
  .clk_dec_g     (clk_dec_g),
  .rst_ni        (rst_ni),
  .clear_i       (clear_i),
  .issue_ready_o (issue_ready_o),
  .sync_o        (sync_o),
  .wake_i        (wake_i),
  .ack_o         (ack_o)
);

/* test/fsync_coproc_tb.sv */
`timescale 1ns/1ps

module fsync_coproc_tb;

  import fsync_pkg::*;

  localparam time CLK_PERIOD = 40ns;
  localparam time DRIVE_DLY  = 2ns;
  localparam int  RST_CYCLES = 5;
  localparam int  NUM_ROWS   = 12;
  localparam int  MAX_DLY    = 7;

  // Expected outcome of a row
  localparam int KIND_BARRIER = 0;
  // Barrier with the next row offered while it waits
  localparam int KIND_HOLD    = 1;
  // Accepted, no barrier
  localparam int KIND_DROP    = 2;
  // Opcode not ours, ready stays low
  localparam int KIND_IGNORE  = 3;
  // Pulse clear_i
  localparam int KIND_CLEAR   = 4;

  logic   clk_dec_g;
  logic   rst_ni;
  logic   clear_i;
  logic   issue_valid_i;
  instr_t issue_instr_i;
  data_t  issue_rs0_i;
  logic   issue_rs_valid_i;
  logic   issue_ready_o;
  logic   issue_accept_o;
  logic   sync_o;
  level_t level_o;
  logic   wake_i;
  logic   error_i;
  logic   ack_o;
  logic   result_valid_o;
  level_t result_level_o;
  logic   result_error_o;
  count_t done_count_o;
  logic   error_status_o;

  // Stimulus table, one entry per row
  instr_t row_instr [NUM_ROWS];
  data_t  row_rs0 [NUM_ROWS];
  logic   row_rs_valid [NUM_ROWS];
  logic   row_err [NUM_ROWS];
  int     row_dly [NUM_ROWS];
  int     row_kind [NUM_ROWS];

  // Network answer for the barrier in flight
  int   net_delay;
  logic net_error;

  int unsigned lcg_state;
  int unsigned error_count;
  count_t      exp_count;
  logic        exp_status;
  // Next row already driven by a hold row
  logic        preoffered;

  fsync_coproc fsync_coproc_inst (
    .clk_dec_g        (clk_dec_g),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .issue_valid_i    (issue_valid_i),
    .issue_instr_i    (issue_instr_i),
    .issue_rs0_i      (issue_rs0_i),
    .issue_rs_valid_i (issue_rs_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_accept_o   (issue_accept_o),
    .sync_o           (sync_o),
    .level_o          (level_o),
    .wake_i           (wake_i),
    .error_i          (error_i),
    .ack_o            (ack_o),
    .result_valid_o   (result_valid_o),
    .result_level_o   (result_level_o),
    .result_error_o   (result_error_o),
    .done_count_o     (done_count_o),
    .error_status_o   (error_status_o)
  );

  initial begin
    clk_dec_g = 1'b0;
    forever #(CLK_PERIOD / 2) clk_dec_g = ~clk_dec_g;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Wake delay of each row comes from the LCG
  task automatic set_row(input int idx, input instr_t instr, input data_t rs0,
                         input logic rs_valid, input logic err, input int kind);
    row_instr[idx]    = instr;
    row_rs0[idx]      = rs0;
    row_rs_valid[idx] = rs_valid;
    row_err[idx]      = err;
    row_dly[idx]      = int'((lcg_next() >> 16) % (MAX_DLY + 1));
    row_kind[idx]     = kind;
  endtask

  task automatic stop_run();
    error_count++;
    $display("Simulation failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input level_t exp, input level_t act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic drive_row(input int idx);
    issue_valid_i    = 1'b1;
    issue_instr_i    = row_instr[idx];
    issue_rs0_i      = row_rs0[idx];
    issue_rs_valid_i = row_rs_valid[idx];
  endtask

  task automatic run_barrier(input int idx);
    level_t exp_level;
    logic   hold;
    // Level is the low bits of rs0
    exp_level = level_t'(row_rs0[idx]);
    hold      = (row_kind[idx] == KIND_HOLD);
    net_delay = row_dly[idx];
    net_error = row_err[idx];
    if (!preoffered) begin
      @(posedge clk_dec_g);
      #DRIVE_DLY;
      drive_row(idx);
      @(negedge clk_dec_g);
    end
    preoffered = 1'b0;
    check_bit("issue_ready_o", 1'b1, issue_ready_o);
    check_bit("issue_accept_o", 1'b1, issue_accept_o);
    @(posedge clk_dec_g);
    #DRIVE_DLY;
    if (hold) begin
      drive_row(idx + 1);
      preoffered = 1'b1;
    end else begin
      issue_valid_i = 1'b0;
    end
    // Request one cycle after the take
    @(negedge clk_dec_g);
    check_bit("sync_o", 1'b1, sync_o);
    check_level("level_o", exp_level, level_o);
    if (hold) check_bit("issue_ready_o", 1'b0, issue_ready_o);
    do begin
      @(negedge clk_dec_g);
      check_bit("sync_o", 1'b0, sync_o);
      if (hold) check_bit("issue_ready_o", 1'b0, issue_ready_o);
    end while (!wake_i);
    @(negedge clk_dec_g);
    check_bit("ack_o", 1'b1, ack_o);
    check_bit("result_valid_o", 1'b0, result_valid_o);
    if (hold) check_bit("issue_ready_o", 1'b0, issue_ready_o);
    // Registered report one cycle after the acknowledge
    @(negedge clk_dec_g);
    exp_count++;
    exp_status = exp_status | row_err[idx];
    check_bit("ack_o", 1'b0, ack_o);
    check_bit("result_valid_o", 1'b1, result_valid_o);
    check_level("result_level_o", exp_level, result_level_o);
    check_bit("result_error_o", row_err[idx], result_error_o);
    check_count("done_count_o", exp_count, done_count_o);
    check_bit("error_status_o", exp_status, error_status_o);
  endtask

  // No barrier may follow whether the row is taken or left alone
  task automatic run_no_barrier(input int idx, input logic exp_ready);
    @(posedge clk_dec_g);
    #DRIVE_DLY;
    drive_row(idx);
    @(negedge clk_dec_g);
    check_bit("issue_ready_o", exp_ready, issue_ready_o);
    check_bit("issue_accept_o", exp_ready, issue_accept_o);
    @(posedge clk_dec_g);
    #DRIVE_DLY;
    issue_valid_i = 1'b0;
    repeat (4) begin
      @(negedge clk_dec_g);
      check_bit("sync_o", 1'b0, sync_o);
      check_bit("result_valid_o", 1'b0, result_valid_o);
      check_count("done_count_o", exp_count, done_count_o);
    end
  endtask

  task automatic run_clear();
    @(posedge clk_dec_g);
    #DRIVE_DLY;
    clear_i = 1'b1;
    @(posedge clk_dec_g);
    #DRIVE_DLY;
    clear_i = 1'b0;
    exp_count  = '0;
    exp_status = 1'b0;
    @(negedge clk_dec_g);
    check_bit("error_status_o", 1'b0, error_status_o);
    check_count("done_count_o", exp_count, done_count_o);
    check_bit("result_valid_o", 1'b0, result_valid_o);
    check_bit("sync_o", 1'b0, sync_o);
    check_bit("ack_o", 1'b0, ack_o);
  endtask

  // Network model answers each request with a wake after the row's delay
  initial begin
    int   dly;
    logic err;
    forever begin
      @(negedge clk_dec_g);
      if (sync_o) begin
        dly = net_delay;
        err = net_error;
        @(posedge clk_dec_g);
        repeat (dly) @(posedge clk_dec_g);
        #DRIVE_DLY;
        wake_i  = 1'b1;
        error_i = err;
        @(posedge clk_dec_g);
        #DRIVE_DLY;
        wake_i  = 1'b0;
        error_i = 1'b0;
      end
    end
  end

  // Bound assertion failures end the run at once
  initial begin
    wait (fsync_coproc_inst.fsync_coproc_sva_inst.fail_count != 0);
    $display("A bound assertion on the DUT failed");
    stop_run();
  end

  initial begin
    repeat (RST_CYCLES + NUM_ROWS * (20 + MAX_DLY)) @(posedge clk_dec_g);
    $display("Watchdog expired, the DUT stopped making progress");
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    issue_valid_i    = 1'b0;
    issue_instr_i    = '0;
    issue_rs0_i      = '0;
    issue_rs_valid_i = 1'b0;
    wake_i           = 1'b0;
    error_i          = 1'b0;
    net_delay        = 0;
    net_error        = 1'b0;
    lcg_state        = 10;
    error_count      = 0;
    exp_count        = '0;
    exp_status       = 1'b0;
    preoffered       = 1'b0;

    // Barrier word is func3 010 with opcode 5B
    set_row(0, 32'h0015205B, 32'h00000003, 1'b1, 1'b0, KIND_BARRIER);
    set_row(1, 32'h0000205B, 32'h000000A5, 1'b1, 1'b1, KIND_BARRIER);
    set_row(2, 32'h0020205B, 32'h0000001C, 1'b1, 1'b0, KIND_HOLD);
    set_row(3, 32'h0000205B, 32'h12345677, 1'b1, 1'b0, KIND_BARRIER);
    set_row(4, 32'h0000207B, 32'h00000004, 1'b1, 1'b0, KIND_IGNORE);
    set_row(5, 32'h0000305B, 32'h00000006, 1'b1, 1'b0, KIND_DROP);
    set_row(6, 32'h0000205B, 32'h00000008, 1'b0, 1'b0, KIND_DROP);
    set_row(7, 32'h0000205B, 32'h0000000F, 1'b1, 1'b0, KIND_BARRIER);
    set_row(8, 32'h00000000, 32'h00000000, 1'b0, 1'b0, KIND_CLEAR);
    set_row(9, 32'h0000205B, 32'hFFFFFFF2, 1'b1, 1'b0, KIND_BARRIER);
    set_row(10, 32'h00002033, 32'h00000001, 1'b1, 1'b0, KIND_IGNORE);
    set_row(11, 32'h0000205B, 32'h00000009, 1'b1, 1'b1, KIND_BARRIER);

    repeat (RST_CYCLES) @(posedge clk_dec_g);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    @(negedge clk_dec_g);
    check_bit("issue_ready_o", 1'b0, issue_ready_o);
    check_bit("issue_accept_o", 1'b0, issue_accept_o);
    check_bit("sync_o", 1'b0, sync_o);
    check_bit("ack_o", 1'b0, ack_o);
    check_bit("result_valid_o", 1'b0, result_valid_o);
    check_bit("result_error_o", 1'b0, result_error_o);
    check_bit("error_status_o", 1'b0, error_status_o);
    check_count("done_count_o", exp_count, done_count_o);

    for (int i = 0; i < NUM_ROWS; i++) begin
      case (row_kind[i])
        KIND_BARRIER, KIND_HOLD: run_barrier(i);
        KIND_DROP:               run_no_barrier(i, 1'b1);
        KIND_IGNORE:             run_no_barrier(i, 1'b0);
        default:                 run_clear();
      endcase
    end

    repeat (2) @(negedge clk_dec_g);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
